// ==== Makefile ====
# Verilator simulation of the pipelined core; override any variable on the command line
VERILATOR ?= verilator
TOP       ?= riscvTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sim.f ====
+incdir+source
source/riscvPkg.sv
source/decodeUnit.sv
source/regFile.sv
source/aluUnit.sv
source/hazardUnit.sv
source/fetchStage.sv
source/riscvCore.sv
test/riscvTb.sv

// ==== source/aluUnit.sv ====
// Integer ALU for the execute stage covering the add, logic, compare and shift operations
`timescale 1ns/1ns
`include "riscvSettings.svh"

module aluUnit (
	input  logic [`RISCV_XLEN-1:0] a,
	input  logic [`RISCV_XLEN-1:0] b,
	input  riscvPkg::aluOpE        op,
	output logic [`RISCV_XLEN-1:0] result
);
	import riscvPkg::*;

	localparam int ShW = $clog2(`RISCV_XLEN);

	logic [ShW-1:0] shamt;
	logic           less;

	assign shamt = b[ShW-1:0];
	assign less  = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluSll:  result = a << shamt;
			aluSlt:  result = {{(`RISCV_XLEN-1){1'b0}}, less};
			aluXor:  result = a ^ b;
			aluSrl:  result = a >> shamt;
			aluSra:  result = $unsigned($signed(a) >>> shamt); // Sign fill
			aluOr:   result = a | b;
			aluAnd:  result = a & b;
			default: result = '0;
		endcase
	end

endmodule

// ==== source/decodeUnit.sv ====
// Decode stage logic turning one instruction into its control bundle, branch flags and immediate
`timescale 1ns/1ns
`include "riscvSettings.svh"

module decodeUnit (
	input  logic [`RISCV_XLEN-1:0] instr,
	output riscvPkg::ctrlS         ctrl,
	output logic                   isBeq,
	output logic                   isBne,
	output logic                   isJal,
	output logic [`RISCV_XLEN-1:0] imm
);
	import riscvPkg::*;

	opcodeE                 opcode;
	logic [2:0]             funct3;
	logic [`RISCV_XLEN-1:0] immI;
	logic [`RISCV_XLEN-1:0] immShamt;
	logic [`RISCV_XLEN-1:0] immS;
	logic [`RISCV_XLEN-1:0] immB;
	logic [`RISCV_XLEN-1:0] immJ;

	// funct3 plus bit 30 to ALU operation; sub only exists in the register form
	function automatic aluOpE aluSel(input logic [2:0] f3, input logic alt, input logic isReg);
		case (f3)
			3'b000:  aluSel = (isReg && alt) ? aluSub : aluAdd;
			3'b001:  aluSel = aluSll;
			3'b010:  aluSel = aluSlt;
			3'b100:  aluSel = aluXor;
			3'b101:  aluSel = alt ? aluSra : aluSrl;
			3'b110:  aluSel = aluOr;
			3'b111:  aluSel = aluAnd;
			default: aluSel = aluAdd; // sltu not supported
		endcase
	endfunction

	assign opcode = opcodeE'(instr[6:2]);
	assign funct3 = instr[14:12];

	// Immediate formats
	assign immI     = {{20{instr[31]}}, instr[31:20]};
	assign immShamt = {27'd0, instr[24:20]};
	assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl  = '0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJal = 1'b0;
		imm   = immI;
		case (opcode)
			opReg: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluSel(funct3, instr[30], 1'b1);
			end
			opImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluSel(funct3, instr[30], 1'b0);
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					imm = immShamt; // Shifts take only the low five bits
				end
			end
			opLoad: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				imm           = immS;
			end
			opBranch: begin
				isBeq = (funct3 == 3'b000);
				isBne = (funct3 == 3'b001);
				imm   = immB;
			end
			opJal: begin
				isJal         = 1'b1;
				ctrl.isJump   = 1'b1;
				ctrl.regWrite = 1'b1;
				imm           = immJ;
			end
			default: begin
				// Unknown opcode stays a no-op
			end
		endcase
	end

endmodule

// ==== source/fetchStage.sv ====
// Fetch stage with the PC, next-PC choice, decode-time branch resolution and the IF/ID register
`timescale 1ns/1ns
`include "riscvSettings.svh"

module fetchStage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   isBeq,
	input  logic                   isBne,
	input  logic                   isJal,
	input  logic [`RISCV_XLEN-1:0] rs1Data,
	input  logic [`RISCV_XLEN-1:0] rs2Data,
	input  logic [`RISCV_XLEN-1:0] imm,
	input  logic [`RISCV_XLEN-1:0] imemData,
	output logic [`RISCV_XLEN-3:0] imemAddr,
	output logic [`RISCV_XLEN-1:0] idPc,
	output logic [`RISCV_XLEN-1:0] idPcPlus4,
	output logic [`RISCV_XLEN-1:0] idInstr
);
	logic [`RISCV_XLEN-1:0] pc;      // Address of the word on imemData
	logic [`RISCV_XLEN-1:0] pcPlus4;
	logic [`RISCV_XLEN-1:0] target;
	logic [`RISCV_XLEN-1:0] nextPc;
	logic                   armed;   // Low for the first cycle out of reset
	logic                   taken;

	assign pcPlus4 = pc + `RISCV_XLEN'd4;
	assign target  = idPc + imm;
	assign taken   = isJal
		| (isBeq & (rs1Data == rs2Data))
		| (isBne & (rs1Data != rs2Data));

	// First cycle re-presents the reset PC so memory returns its word
	always_comb begin
		if (stall || !armed) begin
			nextPc = pc;
		end else if (taken) begin
			nextPc = target;
		end else begin
			nextPc = pcPlus4;
		end
	end

	assign imemAddr = nextPc[`RISCV_XLEN-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc    <= `RISCV_RESET_PC;
			armed <= 1'b0;
		end else begin
			pc    <= nextPc;
			armed <= 1'b1;
		end
	end

	// IF/ID register with the wrong-path word replaced by a NOP on redirect
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idInstr <= `RISCV_NOP;
		end else if (!stall) begin
			idPc      <= pc;
			idPcPlus4 <= pcPlus4;
			idInstr   <= (taken || !armed) ? `RISCV_NOP : imemData;
		end
	end

endmodule

// ==== source/hazardUnit.sv ====
// Operand forwarding selects for execute and the load-use interlock for decode
`timescale 1ns/1ns
`include "riscvSettings.svh"

module hazardUnit (
	input  logic [4:0]       exRs1,
	input  logic [4:0]       exRs2,
	input  logic [4:0]       exRd,
	input  logic [4:0]       exMemRd,
	input  logic [4:0]       memWbRd,
	input  logic             exMemRegWrite,
	input  logic             memWbRegWrite,
	input  logic             exMemRead,     // Execute stage holds a load
	input  logic             exUsesRs2,
	input  logic [4:0]       idRs1,
	input  logic [4:0]       idRs2,
	output riscvPkg::fwdSelE fwdA,
	output riscvPkg::fwdSelE fwdB,
	output logic             loadUse
);
	import riscvPkg::*;

	// Youngest producer wins
	function automatic fwdSelE pickFwd(
		input logic [4:0] src,
		input logic       used,
		input logic [4:0] memRd,
		input logic       memWr,
		input logic [4:0] wbRd,
		input logic       wbWr
	);
		if (!used || src == 5'd0) begin
			pickFwd = fwdNone;
		end else if (memWr && memRd == src) begin
			pickFwd = fwdExMem;
		end else if (wbWr && wbRd == src) begin
			pickFwd = fwdMemWb;
		end else begin
			pickFwd = fwdNone;
		end
	endfunction

	assign fwdA = pickFwd(exRs1, 1'b1, exMemRd, exMemRegWrite, memWbRd, memWbRegWrite);
	assign fwdB = pickFwd(exRs2, exUsesRs2, exMemRd, exMemRegWrite, memWbRd, memWbRegWrite);

	// Load data is not ready until MEM/WB so hold decode one cycle
	assign loadUse = exMemRead && (exRd != 5'd0) && (exRd == idRs1 || exRd == idRs2);

endmodule

// ==== source/regFile.sv ====
// General-purpose register file with two combinational reads and one clocked write
`timescale 1ns/1ns
`include "riscvSettings.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [4:0]             rs1Addr,
	input  logic [4:0]             rs2Addr,
	input  logic [4:0]             rdAddr,
	input  logic [`RISCV_XLEN-1:0] rdData,
	input  logic                   wrEn,
	output logic [`RISCV_XLEN-1:0] rs1Data,
	output logic [`RISCV_XLEN-1:0] rs2Data
);
	logic [`RISCV_XLEN-1:0] regs [`RISCV_REGS];
	logic                   doWrite;

	assign doWrite = wrEn && (rdAddr != 5'd0); // x0 never written

	// Write-through so decode sees the value retiring this cycle
	assign rs1Data = (doWrite && rdAddr == rs1Addr) ? rdData : regs[rs1Addr];
	assign rs2Data = (doWrite && rdAddr == rs2Addr) ? rdData : regs[rs2Addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RISCV_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (doWrite) begin
			regs[rdAddr] <= rdData;
		end
	end

endmodule

// ==== source/riscvCore.sv ====
// Top level of the five-stage core, holding the later stage registers and the port wiring
`timescale 1ns/1ns
`include "riscvSettings.svh"

module riscvCore (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [`RISCV_XLEN-3:0] imemAddr,
	input  logic [`RISCV_XLEN-1:0] imemData,
	input  logic                   imemStall,
	output riscvPkg::dmemReqS      dmemReq,
	input  logic [`RISCV_XLEN-1:0] dmemRdata,
	input  logic                   dmemStall
);
	import riscvPkg::*;

	logic                   portStall;
	logic                   loadUse;
	logic                   frontStall;
	logic [`RISCV_XLEN-1:0] idPcPlus4;
	logic [`RISCV_XLEN-1:0] idInstr;
	logic [`RISCV_XLEN-1:0] imm;
	logic [`RISCV_XLEN-1:0] rs1Data;
	logic [`RISCV_XLEN-1:0] rs2Data;
	ctrlS                   idCtrl;
	logic                   isBeq;
	logic                   isBne;
	logic                   isJal;
	idExS                   idEx;
	idExS                   idExNext;
	exMemS                  exMem;
	exMemS                  exMemNext;
	memWbS                  memWb;
	memWbS                  memWbNext;
	fwdSelE                 fwdA;
	fwdSelE                 fwdB;
	logic [`RISCV_XLEN-1:0] opA;
	logic [`RISCV_XLEN-1:0] rs2Fwd;
	logic [`RISCV_XLEN-1:0] aluB;
	logic [`RISCV_XLEN-1:0] aluOut;
	logic [`RISCV_XLEN-1:0] wbData;

	function automatic logic [`RISCV_XLEN-1:0] fwdPick(
		input fwdSelE                 sel,
		input logic [`RISCV_XLEN-1:0] regVal,
		input logic [`RISCV_XLEN-1:0] exMemVal,
		input logic [`RISCV_XLEN-1:0] memWbVal
	);
		case (sel)
			fwdExMem: fwdPick = exMemVal;
			fwdMemWb: fwdPick = memWbVal;
			default:  fwdPick = regVal;
		endcase
	endfunction

	// Either port stalling freezes every stage
	assign portStall  = imemStall | dmemStall;
	assign frontStall = portStall | loadUse;

	// ====================================================================
	// Fetch and decode
	// ====================================================================
	fetchStage fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (frontStall),
		.isBeq     (isBeq),
		.isBne     (isBne),
		.isJal     (isJal),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.imm       (imm),
		.imemData  (imemData),
		.imemAddr  (imemAddr),
		.idPc      (),
		.idPcPlus4 (idPcPlus4),
		.idInstr   (idInstr)
	);

	decodeUnit decode (
		.instr (idInstr),
		.ctrl  (idCtrl),
		.isBeq (isBeq),
		.isBne (isBne),
		.isJal (isJal),
		.imm   (imm)
	);

	regFile regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1Addr (idInstr[19:15]),
		.rs2Addr (idInstr[24:20]),
		.rdAddr  (memWb.rd),
		.rdData  (wbData),
		.wrEn    (memWb.regWrite && !portStall),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	always_comb begin
		idExNext.ctrl    = loadUse ? ctrlS'('0) : idCtrl; // Bubble on load-use
		idExNext.rs1Data = rs1Data;
		idExNext.rs2Data = rs2Data;
		idExNext.imm     = imm;
		idExNext.rs1     = idInstr[19:15];
		idExNext.rs2     = idInstr[24:20];
		idExNext.rd      = idInstr[11:7];
		idExNext.pcPlus4 = idPcPlus4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idEx.ctrl <= '0;
		end else if (!portStall) begin
			idEx <= idExNext;
		end
	end

	// ====================================================================
	// Execute
	// ====================================================================
	hazardUnit hazard (
		.exRs1         (idEx.rs1),
		.exRs2         (idEx.rs2),
		.exRd          (idEx.rd),
		.exMemRd       (exMem.rd),
		.memWbRd       (memWb.rd),
		.exMemRegWrite (exMem.regWrite),
		.memWbRegWrite (memWb.regWrite),
		.exMemRead     (idEx.ctrl.memRead),
		.exUsesRs2     (!idEx.ctrl.aluSrc || idEx.ctrl.memWrite), // Stores need rs2 data
		.idRs1         (idInstr[19:15]),
		.idRs2         (idInstr[24:20]),
		.fwdA          (fwdA),
		.fwdB          (fwdB),
		.loadUse       (loadUse)
	);

	assign opA    = fwdPick(fwdA, idEx.rs1Data, exMem.aluResult, wbData);
	assign rs2Fwd = fwdPick(fwdB, idEx.rs2Data, exMem.aluResult, wbData);
	assign aluB   = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;

	aluUnit alu (
		.a      (opA),
		.b      (aluB),
		.op     (idEx.ctrl.aluOp),
		.result (aluOut)
	);

	always_comb begin
		exMemNext.aluResult = aluOut;
		exMemNext.storeData = rs2Fwd;
		exMemNext.rd        = idEx.rd;
		exMemNext.pcPlus4   = idEx.pcPlus4;
		exMemNext.memRead   = idEx.ctrl.memRead;
		exMemNext.memWrite  = idEx.ctrl.memWrite;
		exMemNext.memToReg  = idEx.ctrl.memToReg;
		exMemNext.regWrite  = idEx.ctrl.regWrite;
		exMemNext.isJump    = idEx.ctrl.isJump;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.isJump   <= 1'b0;
		end else if (!portStall) begin
			exMem <= exMemNext;
		end
	end

	// ====================================================================
	// Memory and write-back
	// ====================================================================
	assign dmemReq = '{
		read:  exMem.memRead,
		write: exMem.memWrite,
		addr:  exMem.aluResult[`RISCV_XLEN-1:2],
		wdata: exMem.storeData
	};

	always_comb begin
		memWbNext.aluResult = exMem.aluResult;
		memWbNext.loadData  = dmemRdata;
		memWbNext.rd        = exMem.rd;
		memWbNext.pcPlus4   = exMem.pcPlus4;
		memWbNext.memToReg  = exMem.memToReg;
		memWbNext.regWrite  = exMem.regWrite;
		memWbNext.isJump    = exMem.isJump;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memWb.memToReg <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isJump   <= 1'b0;
		end else if (!portStall) begin
			memWb <= memWbNext;
		end
	end

	always_comb begin
		if (memWb.isJump) begin
			wbData = memWb.pcPlus4;  // jal link
		end else if (memWb.memToReg) begin
			wbData = memWb.loadData;
		end else begin
			wbData = memWb.aluResult;
		end
	end

endmodule

// ==== source/riscvPkg.sv ====
// Shared opcode, ALU and forwarding enums plus all pipeline payload structs for the core
`include "riscvSettings.svh"

package riscvPkg;

	// Major opcodes, instruction bits 6:2
	typedef enum logic [4:0] {
		opLoad   = 5'b00000,
		opImm    = 5'b00100,
		opStore  = 5'b01000,
		opReg    = 5'b01100,
		opBranch = 5'b11000,
		opJal    = 5'b11011
	} opcodeE;

	// Encoded as {bit30, funct3} for the R-type forms
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111,
		aluSub = 4'b1000,
		aluSra = 4'b1101
	} aluOpE;

	typedef enum logic [1:0] {
		fwdNone,
		fwdExMem,
		fwdMemWb
	} fwdSelE;

	typedef struct packed {
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  aluSrc;   // Immediate as ALU operand B
		logic  regWrite;
		logic  isJump;   // Write back PC+4
		aluOpE aluOp;
	} ctrlS;

	typedef struct packed {
		ctrlS                   ctrl;
		logic [`RISCV_XLEN-1:0] rs1Data;
		logic [`RISCV_XLEN-1:0] rs2Data;
		logic [`RISCV_XLEN-1:0] imm;
		logic [4:0]             rs1;
		logic [4:0]             rs2;
		logic [4:0]             rd;
		logic [`RISCV_XLEN-1:0] pcPlus4;
	} idExS;

	typedef struct packed {
		logic [`RISCV_XLEN-1:0] aluResult;
		logic [`RISCV_XLEN-1:0] storeData;
		logic [4:0]             rd;
		logic [`RISCV_XLEN-1:0] pcPlus4;
		logic                   memRead;
		logic                   memWrite;
		logic                   memToReg;
		logic                   regWrite;
		logic                   isJump;
	} exMemS;

	typedef struct packed {
		logic [`RISCV_XLEN-1:0] aluResult;
		logic [`RISCV_XLEN-1:0] loadData;
		logic [4:0]             rd;
		logic [`RISCV_XLEN-1:0] pcPlus4;
		logic                   memToReg;
		logic                   regWrite;
		logic                   isJump;
	} memWbS;

	// Word-addressed data port request
	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [`RISCV_XLEN-3:0] addr;
		logic [`RISCV_XLEN-1:0] wdata;
	} dmemReqS;

endpackage

// ==== source/riscvSettings.svh ====
// Core-wide width, reset and encoding constants; include wherever a module needs them

`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Data path and address width
`define RISCV_XLEN 32

// Architectural register count
`define RISCV_REGS 32

// First fetch address after reset
`define RISCV_RESET_PC 32'h0000_0000

// addi x0,x0,0
`define RISCV_NOP 32'h0000_0013

`endif

// ==== test/riscvTb.sv ====
// Directed testbench for the core, with word memories on both ports, program loader and store checks
`timescale 1ns/1ns
`include "riscvSettings.svh"

module riscvTb;
	import riscvPkg::*;

	localparam int ClkPeriod     = 20;
	localparam int NumTests      = 6;
	localparam int CyclesPerTest = 200;
	localparam int ImemWords     = 64;
	localparam int DmemWords     = 256;

	logic                   clk;
	logic                   rst_n;
	logic [`RISCV_XLEN-3:0] imemAddr;
	logic [`RISCV_XLEN-1:0] imemData = `RISCV_NOP;
	logic                   imemStall = 1'b0;
	dmemReqS                dmemReq;
	logic [`RISCV_XLEN-1:0] dmemRdata = '0;
	logic                   dmemStall = 1'b0;

	logic [31:0] imem [ImemWords];
	logic [31:0] dmem [DmemWords];
	logic [31:0] prog[$];
	dmemReqS     stores[$];     // Writes taken by the data memory
	dmemReqS     expStores[$];
	logic [29:0] fetchAddr;
	logic [29:0] endAddr;
	logic [29:0] firstFetch;
	dmemReqS     reqSeen;
	logic        stallSeen;
	logic        rstSeen;
	logic        stallsOn;
	integer      seed;

	riscvCore dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.imemStall (imemStall),
		.dmemReq   (dmemReq),
		.dmemRdata (dmemRdata),
		.dmemStall (dmemStall)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// ====================================================================
	// Memory models
	// ====================================================================
	always @(negedge clk) begin
		fetchAddr = imemAddr;  // Address seen by the next rising edge
		reqSeen   = dmemReq;
		stallSeen = imemStall | dmemStall;
		rstSeen   = rst_n;
	end

	always @(posedge clk) begin
		if (rstSeen && reqSeen.write && !stallSeen) begin
			dmem[reqSeen.addr[7:0]] = reqSeen.wdata;
			stores.push_back(reqSeen);
		end
		#2;
		imemData  = imem[fetchAddr[5:0]];
		dmemRdata = dmem[dmemReq.addr[7:0]];
		imemStall = stallsOn && (($random(seed) & 32'd3) == 32'd0);
		dmemStall = stallsOn && (($random(seed) & 32'd3) == 32'd0);
	end

	// ====================================================================
	// Instruction encoding and reference results
	// ====================================================================
	function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		regOp = {f7, rs2, rs1, f3, rd, opReg, 2'b11};
	endfunction

	function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1);
		immOp = {imm, rs1, f3, rd, opImm, 2'b11};
	endfunction

	function automatic logic [31:0] lwOp(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		lwOp = {imm, rs1, 3'b010, rd, opLoad, 2'b11};
	endfunction

	function automatic logic [31:0] swOp(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		swOp = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore, 2'b11};
	endfunction

	function automatic logic [31:0] brOp(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		brOp = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch, 2'b11};
	endfunction

	function automatic logic [31:0] jalOp(input logic [4:0] rd, input logic [20:0] off);
		jalOp = {off[20], off[10:1], off[11], off[19:12], rd, opJal, 2'b11};
	endfunction

	// ISA result of an integer operation selected by funct3 and bit 30
	function automatic logic [31:0] regRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  regRef = alt ? a - b : a + b;
			3'b001:  regRef = a << b[4:0];
			3'b010:  regRef = {31'd0, $signed(a) < $signed(b)};
			3'b100:  regRef = a ^ b;
			3'b101:  regRef = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  regRef = a | b;
			3'b111:  regRef = a & b;
			default: regRef = '0;
		endcase
	endfunction

	// Data memory contents in which every address bit shows up
	function automatic logic [31:0] fillWord(input logic [7:0] idx);
		fillWord = {idx, ~idx, idx ^ 8'h5a, idx + 8'h37};
	endfunction

	function automatic void addWord(input logic [31:0] w);
		prog.push_back(w);
	endfunction

	function automatic void expectStore(input logic [31:0] byteAddr, input logic [31:0] data);
		dmemReqS req;
		req.read  = 1'b0;
		req.write = 1'b1;
		req.addr  = byteAddr[31:2];
		req.wdata = data;
		expStores.push_back(req);
	endfunction

	// ====================================================================
	// Checks
	// ====================================================================
	task automatic stopWithFailure();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkStore(input string name, input dmemReqS got, input dmemReqS exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkFetch(input string name, input logic [29:0] got, input logic [29:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic compareStores(input string testName);
		if (stores.size() != expStores.size()) begin
			$display("ERROR: test %s saw %0d stores but %0d were expected",
				testName, stores.size(), expStores.size());
			stopWithFailure();
		end
		foreach (expStores[i]) begin
			checkStore("dmemReq", stores[i], expStores[i]);
		end
	endtask

	// ====================================================================
	// Program run
	// ====================================================================
	task automatic resetCore();
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// Loads memories, resets, then waits for the closing self-jal to spin
	task automatic runProgram();
		int      hits;
		dmemReqS prevReq;
		logic    prevStall;
		for (int i = 0; i < ImemWords; i++) begin
			imem[i] = immOp(12'(i), 3'b000, 5'd0, 5'd0); // addi x0,x0,i
		end
		foreach (prog[i]) begin
			imem[i] = prog[i];
		end
		for (int i = 0; i < DmemWords; i++) begin
			dmem[i] = fillWord(8'(i));
		end
		endAddr = 30'(prog.size() - 1);
		stores.delete();
		resetCore();
		@(negedge clk);
		firstFetch = imemAddr;
		prevReq    = dmemReq;
		prevStall  = imemStall | dmemStall;
		hits       = 0;
		while (hits < 12) begin
			@(negedge clk);
			if (prevStall) begin
				checkStore("dmemReq", dmemReq, prevReq); // Frozen across a stalled edge
			end
			prevReq   = dmemReq;
			prevStall = imemStall | dmemStall;
			if (imemAddr == endAddr || imemAddr == endAddr + 30'd1) begin
				if (!prevStall) begin
					hits++;
				end
			end else begin
				hits = 0;
			end
		end
	endtask

	// ====================================================================
	// Tests
	// ====================================================================
	task automatic testRegOps();
		logic [35:0] opList;
		logic [3:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		opList = {4'h0, 4'h8, 4'h7, 4'h6, 4'h4, 4'h2, 4'h1, 4'h5, 4'hd}; // {bit30, funct3}
		a = fillWord(8'h10);
		b = fillWord(8'h11);
		prog.delete();
		expStores.delete();
		addWord(lwOp(5'd1, 5'd0, 12'h040));
		addWord(lwOp(5'd2, 5'd0, 12'h044));
		for (int k = 0; k < 9; k++) begin
			op = opList[35 - 4 * k -: 4];
			addWord(regOp({1'b0, op[3], 5'd0}, op[2:0], 5'd3, 5'd1, 5'd2));
			addWord(swOp(5'd3, 5'd0, 12'h080 + 12'(4 * k)));
			expectStore(32'h80 + 32'(4 * k), regRef(op[2:0], op[3], a, b));
		end
		addWord(jalOp(5'd0, 21'd0));
		runProgram();
		compareStores("register ops");
	endtask

	task automatic testImmOps();
		logic [119:0] iList;
		logic [14:0]  entry;
		logic [31:0]  a;
		logic [31:0]  b;
		iList = {3'b000, 12'h123, 3'b111, 12'h0f0, 3'b110, 12'h800, 3'b100, 12'h7ff,
			3'b010, 12'hffb, 3'b001, 12'h004, 3'b101, 12'h009, 3'b101, 12'h407};
		a = 32'hffff_fc18; // -1000
		prog.delete();
		expStores.delete();
		addWord(immOp(12'hc18, 3'b000, 5'd1, 5'd0));
		for (int k = 0; k < 8; k++) begin
			entry = iList[119 - 15 * k -: 15];
			b     = {{20{entry[11]}}, entry[11:0]};
			addWord(immOp(entry[11:0], entry[14:12], 5'd3, 5'd1));
			addWord(swOp(5'd3, 5'd0, 12'h0c0 + 12'(4 * k)));
			expectStore(32'hc0 + 32'(4 * k),
				regRef(entry[14:12], (entry[14:12] == 3'b101) && entry[10], a, b));
		end
		addWord(jalOp(5'd0, 21'd0));
		runProgram();
		compareStores("immediate ops");
	endtask

	// Dependent chain that the stall test reruns
	task automatic buildChain();
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		logic [31:0] v6;
		v1 = 32'd5;
		v2 = v1 + 32'd3;
		v3 = v2 + v1;
		v4 = v3 << v1[4:0];
		v5 = v4 ^ v2;
		v6 = v5 - 32'd7;
		prog.delete();
		expStores.delete();
		addWord(immOp(12'd5, 3'b000, 5'd1, 5'd0));
		addWord(immOp(12'd3, 3'b000, 5'd2, 5'd1));
		addWord(regOp(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
		addWord(regOp(7'h00, 3'b001, 5'd4, 5'd3, 5'd1));
		addWord(regOp(7'h00, 3'b100, 5'd5, 5'd4, 5'd2));
		addWord(immOp(12'hff9, 3'b000, 5'd6, 5'd5));
		addWord(swOp(5'd6, 5'd0, 12'h100)); // Store data from EX/MEM
		addWord(swOp(5'd5, 5'd0, 12'h104));
		addWord(swOp(5'd4, 5'd0, 12'h108));
		addWord(swOp(5'd3, 5'd0, 12'h10c));
		addWord(swOp(5'd2, 5'd0, 12'h110));
		addWord(jalOp(5'd0, 21'd0));
		expectStore(32'h100, v6);
		expectStore(32'h104, v5);
		expectStore(32'h108, v4);
		expectStore(32'h10c, v3);
		expectStore(32'h110, v2);
	endtask

	task automatic testForwarding();
		buildChain();
		runProgram();
		compareStores("forwarding");
	endtask

	task automatic testLoadUse();
		prog.delete();
		expStores.delete();
		addWord(lwOp(5'd1, 5'd0, 12'h020));
		addWord(regOp(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
		addWord(swOp(5'd2, 5'd0, 12'h140));
		addWord(lwOp(5'd3, 5'd0, 12'h024));
		addWord(lwOp(5'd4, 5'd0, 12'h028));
		addWord(regOp(7'h00, 3'b000, 5'd5, 5'd3, 5'd4));
		addWord(swOp(5'd5, 5'd0, 12'h144));
		addWord(lwOp(5'd6, 5'd0, 12'h02c));
		addWord(swOp(5'd6, 5'd0, 12'h148)); // Loaded word stored right away
		addWord(jalOp(5'd0, 21'd0));
		expectStore(32'h140, fillWord(8'h08) + fillWord(8'h08));
		expectStore(32'h144, fillWord(8'h09) + fillWord(8'h0a));
		expectStore(32'h148, fillWord(8'h0b));
		runProgram();
		compareStores("load-use");
	endtask

	task automatic testBranches();
		logic [31:0] linkExp;
		linkExp = 32'd12 * 32'd4 + 32'd4; // jal sits at word 12
		prog.delete();
		expStores.delete();
		addWord(immOp(12'd7, 3'b000, 5'd1, 5'd0));
		addWord(immOp(12'd7, 3'b000, 5'd2, 5'd0));
		addWord(immOp(12'd9, 3'b000, 5'd3, 5'd0));
		addWord(immOp(12'd1, 3'b000, 5'd10, 5'd0));
		addWord(brOp(3'b000, 5'd1, 5'd2, 13'd8));  // beq taken
		addWord(swOp(5'd10, 5'd0, 12'h0a0));
		addWord(brOp(3'b001, 5'd1, 5'd3, 13'd8));  // bne taken
		addWord(swOp(5'd10, 5'd0, 12'h0a4));
		addWord(brOp(3'b000, 5'd1, 5'd3, 13'd8));  // beq falls through
		addWord(swOp(5'd1, 5'd0, 12'h0a8));
		addWord(brOp(3'b001, 5'd1, 5'd2, 13'd8));  // bne falls through
		addWord(swOp(5'd3, 5'd0, 12'h0ac));
		addWord(jalOp(5'd5, 21'd8));
		addWord(swOp(5'd10, 5'd0, 12'h0b0));
		addWord(swOp(5'd5, 5'd0, 12'h0b4));
		addWord(jalOp(5'd0, 21'd0));
		expectStore(32'ha8, 32'd7);
		expectStore(32'hac, 32'd9);
		expectStore(32'hb4, linkExp);
		runProgram();
		checkFetch("imemAddr", firstFetch, 30'd0);
		checkWord("dmemReq.wdata", stores[2].wdata, linkExp);
		compareStores("branches");
	endtask

	task automatic testStalls();
		buildChain();
		stallsOn = 1'b1;
		runProgram();
		stallsOn = 1'b0;
		compareStores("random stalls");
	endtask

	// ====================================================================
	// Main sequence and watchdog
	// ====================================================================
	initial begin
		rst_n    = 1'b0;
		stallsOn = 1'b0;
		seed     = 32'ha6d7;
		repeat (2) @(posedge clk);
		testRegOps();
		testImmOps();
		testForwarding();
		testLoadUse();
		testBranches();
		testStalls();
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		#(NumTests * CyclesPerTest * ClkPeriod);
		$display("ERROR: the watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog timeout");
	end

endmodule
